//--- rtl/dma_cfg_pkg.sv
// Configuration constants of the cluster DMA
// Widths, requester count and command queue sizing

package dma_cfg_pkg;

  // ******************************
  // Requester side
  // ******************************

  // Cores plus the cluster controller
  localparam int NB_CTRLS   = 3;
  // Enough bits to tag a command with its requester
  localparam int CTRL_ID_W  = 2;
  // Register offset inside one requester port
  localparam int REG_ADDR_W = 2;

  // ******************************
  // Data path
  // ******************************

  localparam int DATA_W  = 32;
  // Word address, same on TCDM and external side
  localparam int ADDR_W  = 16;
  // Transfer length in words, zero moves one word
  localparam int LEN_W   = 8;
  // Direction bit in the REG_LEN_DIR write data
  localparam int DIR_BIT = 31;

  // ******************************
  // Command queue
  // ******************************

  localparam int QUEUE_DEPTH = 4;
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  // Per-requester outstanding count, queue entries plus one in the engine
  localparam int PEND_W      = $clog2(QUEUE_DEPTH + 2);

endpackage

//--- rtl/dma_cmd_pkg.sv
// Encodings of the DMA programming model
// Register offsets, transfer direction and engine FSM states

package dma_cmd_pkg;

  import dma_cfg_pkg::*;

  // ******************************
  // Register map of one requester port
  // ******************************

  // Offsets are word registers, all ports share the same map
  typedef enum logic [REG_ADDR_W-1:0] {
    // Start address on the external bus
    REG_EXT_ADDR  = 2'd0,
    // Start address in the scratchpad
    REG_TCDM_ADDR = 2'd1,
    // Length in bits 7:0, direction in bit 31, the write launches
    REG_LEN_DIR   = 2'd2,
    // Read-only, outstanding transfers of this port
    REG_STATUS    = 2'd3
  } dma_reg_e;

  // Copy direction, selects which bus is read
  typedef enum logic {
    DIR_EXT2TCDM = 1'b0,
    DIR_TCDM2EXT = 1'b1
  } dma_dir_e;

  // ******************************
  // Transfer engine FSM
  // ******************************

  // One word per round trip: read source, wait data, write sink
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    RD_REQ  = 3'd1,
    RD_WAIT = 3'd2,
    WR_REQ  = 3'd3,
    DONE    = 3'd4
  } dma_state_e;

endpackage

//--- rtl/dma_cmd_if.sv
// Transfer command channel with valid/ready handshake
// Source and sink modports

interface dma_cmd_if
  import dma_cfg_pkg::*, dma_cmd_pkg::*;
();

  // Handshake, a transfer happens when both are high
  logic                 valid;
  logic                 ready;

  // Command payload, held stable while valid waits for ready
  logic [ADDR_W-1:0]    ext_addr;
  logic [ADDR_W-1:0]    tcdm_addr;
  logic [LEN_W-1:0]     len;
  dma_dir_e             dir;
  // Issuing requester, returned with the termination
  logic [CTRL_ID_W-1:0] id;

  modport source (
    output valid, ext_addr, tcdm_addr, len, dir, id,
    input  ready
  );

  modport sink (
    input  valid, ext_addr, tcdm_addr, len, dir, id,
    output ready
  );

endinterface

//--- rtl/dma_ctrl_unit.sv
// Requester register ports with round-robin arbitration
// Command launch and per-requester pending counters

module dma_ctrl_unit
  import dma_cfg_pkg::*, dma_cmd_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic [NB_CTRLS-1:0]              ctrl_req_i,
  input  logic [NB_CTRLS-1:0][REG_ADDR_W-1:0] ctrl_add_i,
  input  logic [NB_CTRLS-1:0]              ctrl_wen_i,
  input  logic [NB_CTRLS-1:0][DATA_W-1:0]  ctrl_wdata_i,
  output logic [NB_CTRLS-1:0]              ctrl_gnt_o,
  output logic [NB_CTRLS-1:0]              ctrl_r_valid_o,
  output logic [NB_CTRLS-1:0][DATA_W-1:0]  ctrl_r_rdata_o,
  input  logic                             term_valid_i,
  input  logic [CTRL_ID_W-1:0]             term_id_i,
  output logic                             pending_o,
  dma_cmd_if.source                        cmd
);

  logic [NB_CTRLS-1:0]               elig;
  logic [CTRL_ID_W-1:0]              rr_q;
  logic                              gnt_any;
  logic [CTRL_ID_W-1:0]              gnt_idx;
  dma_reg_e                          gnt_reg;
  logic                              gnt_wr;
  logic                              launch;
  logic [NB_CTRLS-1:0][ADDR_W-1:0]   ext_addr_q;
  logic [NB_CTRLS-1:0][ADDR_W-1:0]   tcdm_addr_q;
  logic [NB_CTRLS-1:0][PEND_W-1:0]   pend_q;
  logic [NB_CTRLS-1:0]               r_valid_q;
  logic [DATA_W-1:0]                 rdata_d;
  logic [DATA_W-1:0]                 rdata_q;

  // ******************************
  // Arbitration
  // ******************************

  // A launch write is held back while the queue is full
  always_comb begin
    for (int i = 0; i < NB_CTRLS; i++) begin
      elig[i] = ctrl_req_i[i];
      if (!ctrl_wen_i[i] && ctrl_add_i[i] == REG_LEN_DIR && !cmd.ready) begin
        elig[i] = 1'b0;
      end
    end
  end

  // Scan downwards so the port right at rr_q wins last
  always_comb begin
    int idx;
    gnt_any = 1'b0;
    gnt_idx = '0;
    for (int k = NB_CTRLS - 1; k >= 0; k--) begin
      idx = (int'(rr_q) + k) % NB_CTRLS;
      if (elig[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = CTRL_ID_W'(idx);
      end
    end
  end

  assign ctrl_gnt_o = gnt_any ? (NB_CTRLS'(1) << gnt_idx) : '0;
  assign gnt_reg    = dma_reg_e'(ctrl_add_i[gnt_idx]);
  // wen low means write
  assign gnt_wr     = gnt_any && !ctrl_wen_i[gnt_idx];
  assign launch     = gnt_wr && gnt_reg == REG_LEN_DIR;

  // Command goes out in the grant cycle, ready is already known high
  assign cmd.valid     = launch;
  assign cmd.ext_addr  = ext_addr_q[gnt_idx];
  assign cmd.tcdm_addr = tcdm_addr_q[gnt_idx];
  assign cmd.len       = ctrl_wdata_i[gnt_idx][LEN_W-1:0];
  assign cmd.dir       = dma_dir_e'(ctrl_wdata_i[gnt_idx][DIR_BIT]);
  assign cmd.id        = gnt_idx;

  // ******************************
  // Registers and response
  // ******************************

  // Private address registers per port
  always_ff @(posedge clk_i) begin
    if (gnt_wr && gnt_reg == REG_EXT_ADDR) begin
      ext_addr_q[gnt_idx] <= ctrl_wdata_i[gnt_idx][ADDR_W-1:0];
    end
    if (gnt_wr && gnt_reg == REG_TCDM_ADDR) begin
      tcdm_addr_q[gnt_idx] <= ctrl_wdata_i[gnt_idx][ADDR_W-1:0];
    end
  end

  // Readback value, sampled at grant
  always_comb begin
    case (gnt_reg)
      REG_EXT_ADDR:  rdata_d = DATA_W'(ext_addr_q[gnt_idx]);
      REG_TCDM_ADDR: rdata_d = DATA_W'(tcdm_addr_q[gnt_idx]);
      REG_STATUS:    rdata_d = DATA_W'(pend_q[gnt_idx]);
      default:       rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (gnt_any) rdata_q <= rdata_d;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q      <= '0;
      r_valid_q <= '0;
      pend_q    <= '0;
    end else begin
      // Response one cycle after every grant, reads and writes alike
      r_valid_q <= ctrl_gnt_o;
      if (gnt_any) begin
        rr_q <= (gnt_idx == CTRL_ID_W'(NB_CTRLS - 1)) ? '0 : gnt_idx + 1'b1;
      end
      // Launch and termination of one port can meet in a cycle
      for (int i = 0; i < NB_CTRLS; i++) begin
        case ({launch && gnt_idx == CTRL_ID_W'(i), term_valid_i && term_id_i == CTRL_ID_W'(i)})
          2'b10:   pend_q[i] <= pend_q[i] + 1'b1;
          2'b01:   pend_q[i] <= pend_q[i] - 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Only one r_valid is ever high, so ports share the data register
  always_comb begin
    for (int i = 0; i < NB_CTRLS; i++) begin
      ctrl_r_rdata_o[i] = rdata_q;
    end
  end

  assign ctrl_r_valid_o = r_valid_q;
  assign pending_o      = |pend_q;

  // Grant only to an eligible port, never the same port twice while another waits
  a_gnt_rr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ctrl_gnt_o & ~elig) == '0 &&
    ((ctrl_gnt_o & $past(ctrl_gnt_o)) == '0 || (elig & ~ctrl_gnt_o) == '0));

  // Engine never terminates a command this port did not launch
  a_pend_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    term_valid_i |-> pend_q[term_id_i] != '0);

endmodule

//--- rtl/dma_cmd_queue.sv
// Global command FIFO between control unit and engine

module dma_cmd_queue
  import dma_cfg_pkg::*, dma_cmd_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  dma_cmd_if.sink   push,
  dma_cmd_if.source pop,
  output logic      empty_o
);

  // Storage split per field
  logic [ADDR_W-1:0]    ext_mem  [QUEUE_DEPTH];
  logic [ADDR_W-1:0]    tcdm_mem [QUEUE_DEPTH];
  logic [LEN_W-1:0]     len_mem  [QUEUE_DEPTH];
  dma_dir_e             dir_mem  [QUEUE_DEPTH];
  logic [CTRL_ID_W-1:0] id_mem   [QUEUE_DEPTH];

  logic [QPTR_W-1:0]    wr_ptr_q;
  logic [QPTR_W-1:0]    rd_ptr_q;
  logic [QPTR_W:0]      count_q;
  logic                 full;
  logic                 wr_en;
  logic                 rd_en;

  assign full       = count_q == (QPTR_W + 1)'(QUEUE_DEPTH);
  assign empty_o    = count_q == '0;
  assign push.ready = !full;
  assign pop.valid  = !empty_o;
  assign wr_en      = push.valid && push.ready;
  assign rd_en      = pop.valid && pop.ready;

  // Head entry, new writes appear here the next cycle
  assign pop.ext_addr  = ext_mem[rd_ptr_q];
  assign pop.tcdm_addr = tcdm_mem[rd_ptr_q];
  assign pop.len       = len_mem[rd_ptr_q];
  assign pop.dir       = dir_mem[rd_ptr_q];
  assign pop.id        = id_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      ext_mem[wr_ptr_q]  <= push.ext_addr;
      tcdm_mem[wr_ptr_q] <= push.tcdm_addr;
      len_mem[wr_ptr_q]  <= push.len;
      dir_mem[wr_ptr_q]  <= push.dir;
      id_mem[wr_ptr_q]   <= push.id;
    end
  end

  // Depth is a power of two, pointers wrap by themselves
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + (QPTR_W + 1)'(wr_en) - (QPTR_W + 1)'(rd_en);
    end
  end

  // Control unit must hold back the launch grant while full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push.valid |-> !full);

endmodule

//--- rtl/dma_xfer_engine.sv
// Word-by-word copy engine between TCDM and external bus
// Termination pulse per finished command

module dma_xfer_engine
  import dma_cfg_pkg::*, dma_cmd_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  dma_cmd_if.sink              cmd,
  output logic                 tcdm_req_o,
  output logic [ADDR_W-1:0]    tcdm_add_o,
  output logic                 tcdm_wen_o,
  output logic [DATA_W-1:0]    tcdm_wdata_o,
  input  logic                 tcdm_gnt_i,
  input  logic                 tcdm_r_valid_i,
  input  logic [DATA_W-1:0]    tcdm_r_rdata_i,
  output logic                 ext_req_o,
  output logic [ADDR_W-1:0]    ext_add_o,
  output logic                 ext_wen_o,
  output logic [DATA_W-1:0]    ext_wdata_o,
  input  logic                 ext_gnt_i,
  input  logic                 ext_r_valid_i,
  input  logic [DATA_W-1:0]    ext_r_rdata_i,
  output logic                 term_valid_o,
  output logic [CTRL_ID_W-1:0] term_id_o,
  output logic                 active_o
);

  dma_state_e           state_q;
  dma_state_e           state_d;
  logic [ADDR_W-1:0]    ext_addr_q;
  logic [ADDR_W-1:0]    tcdm_addr_q;
  // Words left after the current one
  logic [LEN_W-1:0]     rem_q;
  dma_dir_e             dir_q;
  logic [CTRL_ID_W-1:0] id_q;
  logic [DATA_W-1:0]    data_q;
  logic                 ext_is_src;
  logic                 rd_req;
  logic                 wr_req;
  logic                 src_gnt;
  logic                 src_r_valid;
  logic [DATA_W-1:0]    src_rdata;
  logic                 dst_gnt;

  // ******************************
  // Source and sink steering
  // ******************************

  assign ext_is_src  = dir_q == DIR_EXT2TCDM;
  assign rd_req      = state_q == RD_REQ;
  assign wr_req      = state_q == WR_REQ;

  assign src_gnt     = ext_is_src ? ext_gnt_i     : tcdm_gnt_i;
  assign src_r_valid = ext_is_src ? ext_r_valid_i : tcdm_r_valid_i;
  assign src_rdata   = ext_is_src ? ext_r_rdata_i : tcdm_r_rdata_i;
  assign dst_gnt     = ext_is_src ? tcdm_gnt_i    : ext_gnt_i;

  assign ext_req_o    = ext_is_src ? rd_req : wr_req;
  assign tcdm_req_o   = ext_is_src ? wr_req : rd_req;
  // wen high is a read, only the sink ever writes
  assign ext_wen_o    = !wr_req;
  assign tcdm_wen_o   = !wr_req;
  assign ext_add_o    = ext_addr_q;
  assign tcdm_add_o   = tcdm_addr_q;
  assign ext_wdata_o  = data_q;
  assign tcdm_wdata_o = data_q;

  // ******************************
  // FSM
  // ******************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (cmd.valid) state_d = RD_REQ;
      RD_REQ:  if (src_gnt) state_d = RD_WAIT;
      RD_WAIT: if (src_r_valid) state_d = WR_REQ;
      WR_REQ: begin
        if (dst_gnt) state_d = (rem_q == '0) ? DONE : RD_REQ;
      end
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Command latch, address walk and read data capture
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && cmd.valid) begin
      ext_addr_q  <= cmd.ext_addr;
      tcdm_addr_q <= cmd.tcdm_addr;
      // Zero length still moves one word
      rem_q       <= (cmd.len == '0) ? '0 : cmd.len - 1'b1;
      dir_q       <= cmd.dir;
      id_q        <= cmd.id;
    end else if (wr_req && dst_gnt) begin
      ext_addr_q  <= ext_addr_q + 1'b1;
      tcdm_addr_q <= tcdm_addr_q + 1'b1;
      rem_q       <= rem_q - 1'b1;
    end
    if (state_q == RD_WAIT && src_r_valid) begin
      data_q <= src_rdata;
    end
  end

  assign cmd.ready    = state_q == IDLE;
  assign term_valid_o = state_q == DONE;
  assign term_id_o    = id_q;
  assign active_o     = state_q != IDLE;

  a_one_bus: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(tcdm_req_o && ext_req_o));

  // Request fields frozen until the bus grants
  a_tcdm_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    tcdm_req_o && !tcdm_gnt_i |=>
      tcdm_req_o && $stable({tcdm_add_o, tcdm_wen_o, tcdm_wdata_o}));

  a_ext_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ext_req_o && !ext_gnt_i |=>
      ext_req_o && $stable({ext_add_o, ext_wen_o, ext_wdata_o}));

endmodule

//--- rtl/dma_wrap.sv
// Cluster DMA top level with plain requester and memory ports
// Termination event decode and busy flag

module dma_wrap
  import dma_cfg_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Requester register ports
  input  logic [NB_CTRLS-1:0]                 ctrl_req_i,
  input  logic [NB_CTRLS-1:0][REG_ADDR_W-1:0] ctrl_add_i,
  input  logic [NB_CTRLS-1:0]                 ctrl_wen_i,
  input  logic [NB_CTRLS-1:0][DATA_W-1:0]     ctrl_wdata_i,
  output logic [NB_CTRLS-1:0]                 ctrl_gnt_o,
  output logic [NB_CTRLS-1:0]                 ctrl_r_valid_o,
  output logic [NB_CTRLS-1:0][DATA_W-1:0]     ctrl_r_rdata_o,
  // Scratchpad bus
  output logic                                tcdm_req_o,
  output logic [ADDR_W-1:0]                   tcdm_add_o,
  output logic                                tcdm_wen_o,
  output logic [DATA_W-1:0]                   tcdm_wdata_o,
  input  logic                                tcdm_gnt_i,
  input  logic                                tcdm_r_valid_i,
  input  logic [DATA_W-1:0]                   tcdm_r_rdata_i,
  // External memory bus
  output logic                                ext_req_o,
  output logic [ADDR_W-1:0]                   ext_add_o,
  output logic                                ext_wen_o,
  output logic [DATA_W-1:0]                   ext_wdata_o,
  input  logic                                ext_gnt_i,
  input  logic                                ext_r_valid_i,
  input  logic [DATA_W-1:0]                   ext_r_rdata_i,
  output logic [NB_CTRLS-1:0]                 term_event_o,
  output logic                                busy_o
);

  logic                 term_valid;
  logic [CTRL_ID_W-1:0] term_id;
  logic                 pending;
  logic                 queue_empty;
  logic                 engine_active;

  dma_cmd_if cmd_push_if ();
  dma_cmd_if cmd_pop_if ();

  dma_ctrl_unit u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .ctrl_req_i     ( ctrl_req_i     ),
    .ctrl_add_i     ( ctrl_add_i     ),
    .ctrl_wen_i     ( ctrl_wen_i     ),
    .ctrl_wdata_i   ( ctrl_wdata_i   ),
    .ctrl_gnt_o     ( ctrl_gnt_o     ),
    .ctrl_r_valid_o ( ctrl_r_valid_o ),
    .ctrl_r_rdata_o ( ctrl_r_rdata_o ),
    .term_valid_i   ( term_valid     ),
    .term_id_i      ( term_id        ),
    .pending_o      ( pending        ),
    .cmd            ( cmd_push_if    )
  );

  dma_cmd_queue u_queue (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .push    ( cmd_push_if ),
    .pop     ( cmd_pop_if  ),
    .empty_o ( queue_empty )
  );

  dma_xfer_engine u_engine (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .cmd            ( cmd_pop_if     ),
    .tcdm_req_o     ( tcdm_req_o     ),
    .tcdm_add_o     ( tcdm_add_o     ),
    .tcdm_wen_o     ( tcdm_wen_o     ),
    .tcdm_wdata_o   ( tcdm_wdata_o   ),
    .tcdm_gnt_i     ( tcdm_gnt_i     ),
    .tcdm_r_valid_i ( tcdm_r_valid_i ),
    .tcdm_r_rdata_i ( tcdm_r_rdata_i ),
    .ext_req_o      ( ext_req_o      ),
    .ext_add_o      ( ext_add_o      ),
    .ext_wen_o      ( ext_wen_o      ),
    .ext_wdata_o    ( ext_wdata_o    ),
    .ext_gnt_i      ( ext_gnt_i      ),
    .ext_r_valid_i  ( ext_r_valid_i  ),
    .ext_r_rdata_i  ( ext_r_rdata_i  ),
    .term_valid_o   ( term_valid     ),
    .term_id_o      ( term_id        ),
    .active_o       ( engine_active  )
  );

  // One event line per requester
  assign term_event_o = term_valid ? (NB_CTRLS'(1) << term_id) : '0;

  // Launched and not yet terminated on any port
  assign busy_o = pending;

  // Queue entries and the running command are always counted as pending
  a_busy_cover: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pending |-> queue_empty && !engine_active);

endmodule

//--- verification/dma_checker.sv
// Scoreboard for the DMA: predicted writes, status reads, events and busy

module dma_checker
  import dma_cfg_pkg::*, dma_cmd_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [NB_CTRLS-1:0][REG_ADDR_W-1:0] ctrl_add_i,
  input  logic [NB_CTRLS-1:0]                 ctrl_wen_i,
  input  logic [NB_CTRLS-1:0][DATA_W-1:0]     ctrl_wdata_i,
  input  logic [NB_CTRLS-1:0]                 ctrl_gnt_i,
  input  logic [NB_CTRLS-1:0]                 ctrl_r_valid_i,
  input  logic [NB_CTRLS-1:0][DATA_W-1:0]     ctrl_r_rdata_i,
  input  logic                                tcdm_req_i, tcdm_wen_i, tcdm_gnt_i,
  input  logic [ADDR_W-1:0]                   tcdm_add_i,
  input  logic [DATA_W-1:0]                   tcdm_wdata_i,
  input  logic                                ext_req_i, ext_wen_i, ext_gnt_i,
  input  logic [ADDR_W-1:0]                   ext_add_i,
  input  logic [DATA_W-1:0]                   ext_wdata_i,
  input  logic [NB_CTRLS-1:0]                 term_event_i,
  input  logic                                busy_i,
  output int                                  errors_o,
  output logic                                idle_o
);

  logic [ADDR_W-1:0]          ext_reg [NB_CTRLS];
  logic [ADDR_W-1:0]          tcdm_reg [NB_CTRLS];
  int                         cnt [NB_CTRLS];
  int                         stat_exp [NB_CTRLS];
  logic [NB_CTRLS-1:0]        gnt_q;
  logic [NB_CTRLS-1:0]        stat_q;
  // Expected writes as {bus, addr, data}, bus 1 is external
  logic [ADDR_W+DATA_W:0]     exp_q [$];
  int                         words_q [$];
  int                         id_q [$];
  int                         errors;

  assign errors_o = errors;
  assign idle_o   = exp_q.size() == 0 && id_q.size() == 0;

  task automatic report_mismatch(input string msg);
    $display("Fail at time %0t: %s", $time, msg);
    errors++;
  endtask

  // Expand one launch into its destination writes
  task automatic predict(input int p, input logic [DATA_W-1:0] wd);
    int n;
    n = (wd[LEN_W-1:0] == 0) ? 1 : int'(wd[LEN_W-1:0]);
    for (int k = 0; k < n; k++) begin
      if (wd[DIR_BIT] == 1'b0) begin
        exp_q.push_back({1'b0, ADDR_W'(tcdm_reg[p] + k), 32'h2000_0000 + ext_reg[p] + k});
      end else begin
        exp_q.push_back({1'b1, ADDR_W'(ext_reg[p] + k), 32'h1000_0000 + tcdm_reg[p] + k});
      end
    end
    words_q.push_back(n);
    id_q.push_back(p);
    cnt[p]++;
  endtask

  task automatic check_write(input logic bus, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d);
    logic [ADDR_W+DATA_W:0] e;
    if (exp_q.size() == 0) begin
      $display("Write to %s address %h was never expected", bus ? "ext" : "tcdm", a);
      errors++;
    end else begin
      e = exp_q.pop_front();
      if (e != {bus, a, d}) begin
        report_mismatch($sformatf("write bus %0d addr %h data %h, expected bus %0d addr %h data %h",
                                  bus, a, d, e[ADDR_W+DATA_W], e[ADDR_W+DATA_W-1:DATA_W],
                                  e[DATA_W-1:0]));
      end
      if (words_q.size() > 0) words_q[0]--;
    end
  endtask

  always @(posedge clk_i or negedge rst_n_i) begin
    int id;
    if (!rst_n_i) begin
      gnt_q  <= '0;
      stat_q <= '0;
      errors = 0;
      exp_q.delete();
      words_q.delete();
      id_q.delete();
      for (int i = 0; i < NB_CTRLS; i++) cnt[i] = 0;
    end else begin
      if (!$onehot0(ctrl_gnt_i)) report_mismatch("more than one register grant");
      if (ctrl_r_valid_i != gnt_q) report_mismatch("r_valid does not follow grant");
      // Busy is high exactly while a launched transfer has no event yet
      if (busy_i != (id_q.size() != 0)) report_mismatch("busy_o level wrong");
      for (int i = 0; i < NB_CTRLS; i++) begin
        if (ctrl_r_valid_i[i] && stat_q[i] && ctrl_r_rdata_i[i] != DATA_W'(stat_exp[i])) begin
          report_mismatch($sformatf("status port %0d read %0d, expected %0d", i,
                                    ctrl_r_rdata_i[i], stat_exp[i]));
        end
      end
      gnt_q  <= ctrl_gnt_i;
      stat_q <= '0;
      for (int i = 0; i < NB_CTRLS; i++) begin
        if (ctrl_gnt_i[i] && ctrl_wen_i[i] && ctrl_add_i[i] == REG_STATUS) begin
          stat_q[i]   <= 1'b1;
          stat_exp[i] <= cnt[i];
        end
        if (ctrl_gnt_i[i] && !ctrl_wen_i[i]) begin
          case (ctrl_add_i[i])
            REG_EXT_ADDR:  ext_reg[i]  = ctrl_wdata_i[i][ADDR_W-1:0];
            REG_TCDM_ADDR: tcdm_reg[i] = ctrl_wdata_i[i][ADDR_W-1:0];
            REG_LEN_DIR:   predict(i, ctrl_wdata_i[i]);
            default: ;
          endcase
        end
      end
      if (tcdm_req_i && tcdm_gnt_i && !tcdm_wen_i) check_write(1'b0, tcdm_add_i, tcdm_wdata_i);
      if (ext_req_i && ext_gnt_i && !ext_wen_i) check_write(1'b1, ext_add_i, ext_wdata_i);
      if (term_event_i != '0) begin
        if (id_q.size() == 0 || !$onehot(term_event_i)) begin
          $display("Termination event %b with no matching launched transfer", term_event_i);
          errors++;
        end else begin
          id = id_q.pop_front();
          if (term_event_i != NB_CTRLS'(1) << id) begin
            report_mismatch($sformatf("event %b, expected port %0d", term_event_i, id));
          end
          if (words_q.pop_front() != 0) report_mismatch("event before all writes");
          cnt[id]--;
        end
      end
    end
  end

endmodule

//--- verification/dma_tb.sv
// Testbench top for the cluster DMA
// Clock, reset, memory models, stimulus table and watchdog

module dma_tb
  import dma_cfg_pkg::*, dma_cmd_pkg::*;
();

  // ******************************
  // Stimulus table
  // ******************************

  // One row per transfer, rows of one group are launched together
  localparam int NROWS = 11;
  localparam int NGRPS = 5;
  localparam int T_GRP [NROWS]  = '{0, 1, 2, 2, 2, 3, 3, 3, 3, 3, 4};
  localparam int T_PORT [NROWS] = '{0, 1, 0, 1, 2, 0, 0, 1, 1, 2, 2};
  localparam int T_EXT [NROWS]  = '{'h10, 'h30, 'h50, 'h70, 'h90, 'hb0, 'hb8, 'hd0, 'hd8,
                                    'hf0, 'h05};
  localparam int T_TCDM [NROWS] = '{'h20, 'h40, 'h60, 'h80, 'ha0, 'hc0, 'hc8, 'he0, 'he8,
                                    'hf8, 'h08};
  localparam int T_LEN [NROWS]  = '{4, 8, 2, 3, 2, 3, 3, 4, 2, 3, 0};
  // 0 is external to TCDM, 1 is TCDM to external
  localparam int T_DIR [NROWS]  = '{0, 1, 0, 1, 0, 0, 1, 0, 1, 0, 0};

  logic                                clk_i;
  logic                                rst_n_i;
  logic [NB_CTRLS-1:0]                 ctrl_req;
  logic [NB_CTRLS-1:0][REG_ADDR_W-1:0] ctrl_add;
  logic [NB_CTRLS-1:0]                 ctrl_wen;
  logic [NB_CTRLS-1:0][DATA_W-1:0]     ctrl_wdata;
  logic [NB_CTRLS-1:0]                 ctrl_gnt;
  logic [NB_CTRLS-1:0]                 ctrl_r_valid;
  logic [NB_CTRLS-1:0][DATA_W-1:0]     ctrl_r_rdata;
  logic                                tcdm_req, tcdm_wen, tcdm_gnt, tcdm_r_valid;
  logic [ADDR_W-1:0]                   tcdm_add;
  logic [DATA_W-1:0]                   tcdm_wdata, tcdm_r_rdata;
  logic                                ext_req, ext_wen, ext_gnt, ext_r_valid;
  logic [ADDR_W-1:0]                   ext_add;
  logic [DATA_W-1:0]                   ext_wdata, ext_r_rdata;
  logic [NB_CTRLS-1:0]                 term_event;
  logic                                busy;

  // Memory models, one pending read per bus
  logic [DATA_W-1:0] tcdm_mem [256];
  logic [DATA_W-1:0] ext_mem [256];
  logic              tcdm_rd_pend, ext_rd_pend;
  logic [DATA_W-1:0] tcdm_rd_data, ext_rd_data;
  integer            seed;
  int                evt_cnt;
  int                tb_err;
  int                chk_errors;
  logic              chk_idle;

  dma_wrap u_dut (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .ctrl_req_i (ctrl_req), .ctrl_add_i (ctrl_add), .ctrl_wen_i (ctrl_wen),
    .ctrl_wdata_i (ctrl_wdata), .ctrl_gnt_o (ctrl_gnt), .ctrl_r_valid_o (ctrl_r_valid),
    .ctrl_r_rdata_o (ctrl_r_rdata),
    .tcdm_req_o (tcdm_req), .tcdm_add_o (tcdm_add), .tcdm_wen_o (tcdm_wen),
    .tcdm_wdata_o (tcdm_wdata), .tcdm_gnt_i (tcdm_gnt), .tcdm_r_valid_i (tcdm_r_valid),
    .tcdm_r_rdata_i (tcdm_r_rdata),
    .ext_req_o (ext_req), .ext_add_o (ext_add), .ext_wen_o (ext_wen),
    .ext_wdata_o (ext_wdata), .ext_gnt_i (ext_gnt), .ext_r_valid_i (ext_r_valid),
    .ext_r_rdata_i (ext_r_rdata),
    .term_event_o (term_event), .busy_o (busy)
  );

  dma_checker u_chk (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .ctrl_add_i (ctrl_add), .ctrl_wen_i (ctrl_wen), .ctrl_wdata_i (ctrl_wdata),
    .ctrl_gnt_i (ctrl_gnt), .ctrl_r_valid_i (ctrl_r_valid), .ctrl_r_rdata_i (ctrl_r_rdata),
    .tcdm_req_i (tcdm_req), .tcdm_add_i (tcdm_add), .tcdm_wen_i (tcdm_wen),
    .tcdm_wdata_i (tcdm_wdata), .tcdm_gnt_i (tcdm_gnt),
    .ext_req_i (ext_req), .ext_add_i (ext_add), .ext_wen_i (ext_wen),
    .ext_wdata_i (ext_wdata), .ext_gnt_i (ext_gnt),
    .term_event_i (term_event), .busy_i (busy),
    .errors_o (chk_errors), .idle_o (chk_idle)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ******************************
  // Memory models
  // ******************************

  // Grants and read returns change on the falling edge only
  always @(negedge clk_i) begin
    tcdm_gnt     = ($random(seed) & 3) != 0;
    ext_gnt      = ($random(seed) & 3) != 0;
    tcdm_r_valid = tcdm_rd_pend;
    ext_r_valid  = ext_rd_pend;
    tcdm_r_rdata = tcdm_rd_data;
    ext_r_rdata  = ext_rd_data;
  end

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tcdm_rd_pend <= 1'b0;
      ext_rd_pend  <= 1'b0;
      for (int a = 0; a < 256; a++) begin
        tcdm_mem[a] <= 32'h1000_0000 + a;
        ext_mem[a]  <= 32'h2000_0000 + a;
      end
    end else begin
      tcdm_rd_pend <= tcdm_req && tcdm_gnt && tcdm_wen;
      ext_rd_pend  <= ext_req && ext_gnt && ext_wen;
      if (tcdm_req && tcdm_gnt && tcdm_wen) tcdm_rd_data <= tcdm_mem[tcdm_add[7:0]];
      if (tcdm_req && tcdm_gnt && !tcdm_wen) tcdm_mem[tcdm_add[7:0]] <= tcdm_wdata;
      if (ext_req && ext_gnt && ext_wen) ext_rd_data <= ext_mem[ext_add[7:0]];
      if (ext_req && ext_gnt && !ext_wen) ext_mem[ext_add[7:0]] <= ext_wdata;
    end
  end

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) evt_cnt <= 0;
    else evt_cnt <= evt_cnt + $countones(term_event);
  end

  // ******************************
  // Register access
  // ******************************

  // One access on port p, holds req until the grant and returns the response data
  task automatic reg_access(input int p, input dma_reg_e addr, input logic rd,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    logic granted;
    @(negedge clk_i);
    ctrl_req[p]   = 1'b1;
    ctrl_add[p]   = addr;
    ctrl_wen[p]   = rd;
    ctrl_wdata[p] = wdata;
    granted = 1'b0;
    while (!granted) begin
      #1 granted = ctrl_gnt[p];
      @(posedge clk_i);
      if (!granted) @(negedge clk_i);
    end
    @(negedge clk_i);
    ctrl_req[p] = 1'b0;
    rdata = ctrl_r_rdata[p];
  endtask

  // Launch every row of group g that belongs to port p, in table order
  task automatic launch_port(input int p, input int g);
    logic [DATA_W-1:0] rd;
    for (int r = 0; r < NROWS; r++) begin
      if (T_GRP[r] == g && T_PORT[r] == p) begin
        reg_access(p, REG_EXT_ADDR, 1'b0, DATA_W'(T_EXT[r]), rd);
        reg_access(p, REG_TCDM_ADDR, 1'b0, DATA_W'(T_TCDM[r]), rd);
        reg_access(p, REG_LEN_DIR, 1'b0, {T_DIR[r][0], 23'd0, T_LEN[r][7:0]}, rd);
        // Status just after launch, compared by the checker
        reg_access(p, REG_STATUS, 1'b1, '0, rd);
      end
    end
  endtask

  // ******************************
  // Watchdog
  // ******************************

  // Budget grows with the total number of words in the table
  initial begin
    int limit;
    limit = 500;
    for (int r = 0; r < NROWS; r++) begin
      limit += 40 * ((T_LEN[r] == 0) ? 1 : T_LEN[r]);
    end
    repeat (limit) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, run did not complete", limit);
    $display("Test failures found");
    $finish;
  end

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    int words;
    int target;
    int waited;
    logic [DATA_W-1:0] rd;
    seed       = 32'h8b5c;
    tb_err     = 0;
    target     = 0;
    rst_n_i    = 1'b0;
    ctrl_req   = '0;
    ctrl_add   = '0;
    ctrl_wen   = '1;
    ctrl_wdata = '0;
    tcdm_gnt = 1'b0;
    ext_gnt = 1'b0;
    tcdm_r_valid = 1'b0;
    ext_r_valid = 1'b0;
    tcdm_r_rdata = '0;
    ext_r_rdata = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    for (int g = 0; g < NGRPS; g++) begin
      words = 0;
      for (int r = 0; r < NROWS; r++) begin
        if (T_GRP[r] == g) begin
          target++;
          words += (T_LEN[r] == 0) ? 1 : T_LEN[r];
        end
      end
      // All ports start in the same cycle
      for (int p = 0; p < NB_CTRLS; p++) begin
        fork
          automatic int pp = p;
          launch_port(pp, g);
        join_none
      end
      wait fork;
      waited = 0;
      while (evt_cnt < target && waited < words * 40 + 100) begin
        @(posedge clk_i);
        waited++;
      end
      if (evt_cnt < target) begin
        $display("Test %0d: termination event missing, %0d of %0d seen", g, evt_cnt, target);
        tb_err++;
      end
      repeat (2) @(posedge clk_i);
      for (int p = 0; p < NB_CTRLS; p++) begin
        reg_access(p, REG_STATUS, 1'b1, '0, rd);
      end
      $display("Test %0d done: %0d words, checker errors so far %0d", g, words, chk_errors);
    end

    repeat (4) @(posedge clk_i);
    if (!chk_idle) begin
      $display("Expected writes or events were never seen");
      tb_err++;
    end
    $display("Tests: %0d, checker errors: %0d, other failures: %0d", NGRPS, chk_errors, tb_err);
    if (chk_errors == 0 && tb_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- compile.f
rtl/dma_cfg_pkg.sv
rtl/dma_cmd_pkg.sv
rtl/dma_cmd_if.sv
rtl/dma_ctrl_unit.sv
rtl/dma_cmd_queue.sv
rtl/dma_xfer_engine.sv
rtl/dma_wrap.sv
verification/dma_checker.sv
verification/dma_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module dma_tb \
  -o dma_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/dma_sim > sim.log 2>&1
grep -q "All tests passed!" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
